// ==== include/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// Up to eight steps per instruction
`define CPU_STEP_W 3

// Upper address byte used by LDH (n),A
`define CPU_HIGH_PAGE 8'hFF

`define CPU_RESET_PC 16'h0000

`endif

// ==== design/cpu_isa_pkg.sv ====
`include "cpu_defs.svh"

package cpu_isa_pkg;

    // Don't-care bits are marked with ? and matched by casez
    typedef enum logic [`CPU_DATA_W-1:0] {
        NOP      = 8'b0000_0000,
        INCDEC_R = 8'b00??_?10?,
        LD_R_N   = 8'b00??_?110,
        JR_E     = 8'b0001_1000,
        JR_CC_E  = 8'b001?_?000,
        LD_R_R   = 8'b01??_????,
        ALU_A_R  = 8'b10??_????,
        ALU_A_N  = 8'b11??_?110,
        LDH_N_A  = 8'b1110_0000
    } opcode_t;

    // Order follows opcode bits [5:3]
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_XOR,
        ALU_OR,
        ALU_CP
    } alu_op_t;

    typedef enum logic [1:0] {
        COND_NZ,
        COND_Z,
        COND_NC,
        COND_C
    } cond_t;

    typedef enum logic [3:0] {
        NONE = 4'd0,
        Z    = 4'd1,                     // Temporary for immediates
        B    = 4'd2,
        C    = 4'd3,
        D    = 4'd4,
        E    = 4'd5,
        H    = 4'd6,
        L    = 4'd7,
        A    = 4'd8,
        MEM  = 4'd9
    } reg8_t;

endpackage

// ==== design/cpu_dp_pkg.sv ====
`include "cpu_defs.svh"

package cpu_dp_pkg;

    typedef logic [`CPU_DATA_W-1:0] byte_t;
    typedef logic [`CPU_ADDR_W-1:0] addr_t;
    typedef logic [`CPU_STEP_W-1:0] step_t;

    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

    // Encoding matches the register index of the decoder
    typedef enum logic [3:0] {
        DB_NONE = 4'd0,
        DB_Z    = 4'd1,
        DB_B    = 4'd2,
        DB_C    = 4'd3,
        DB_D    = 4'd4,
        DB_E    = 4'd5,
        DB_H    = 4'd6,
        DB_L    = 4'd7,
        DB_A    = 4'd8,
        DB_MEM  = 4'd9
    } s_db_t;

    typedef enum logic [1:0] {
        R_WB_DB  = 2'd0,
        R_WB_ALU = 2'd1
    } s_r_wb_t;

    typedef enum logic [1:0] {
        AB_PC     = 2'd0,
        AB_HIGH_Z = 2'd1                 // FF00 page plus Z
    } ab_sel_t;

endpackage

// ==== design/cpu_sequencer.sv ====
`include "cpu_defs.svh"

module cpu_sequencer (
    input  logic               clk,
    input  logic               rst,
    input  logic               step_done,
    input  logic               done,
    input  logic               is_cond,
    input  cpu_isa_pkg::cond_t cond,
    input  cpu_dp_pkg::step_t  next_step,
    input  cpu_dp_pkg::flags_t flags,
    input  cpu_dp_pkg::byte_t  rd_data,
    output cpu_dp_pkg::byte_t  ir,
    output cpu_dp_pkg::step_t  step
);
    import cpu_isa_pkg::*;

    logic matched;

    always_comb begin
        case (cond)
            COND_NZ: matched = !flags.z;
            COND_Z:  matched = flags.z;
            COND_NC: matched = !flags.c;
            default: matched = flags.c;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ir   <= NOP;                     // First step fetches from the reset PC
            step <= '0;
        end else if (step_done) begin
            if (done) begin
                ir   <= rd_data;             // Opcode read by the done step
                step <= '0;
            end else if (is_cond && !matched) begin
                step <= next_step;
            end else begin
                step <= step + `CPU_STEP_W'd1;
            end
        end
    end

endmodule

// ==== design/cpu_decoder.sv ====
`include "cpu_defs.svh"

module cpu_decoder (
    input  cpu_dp_pkg::byte_t    ir,
    input  cpu_dp_pkg::step_t    step,
    output logic                 done,
    output logic                 is_cond,
    output cpu_isa_pkg::cond_t   cond,
    output cpu_dp_pkg::step_t    next_step,
    output cpu_dp_pkg::ab_sel_t  s_ab,
    output cpu_isa_pkg::reg8_t   s_db,
    output cpu_isa_pkg::reg8_t   t_db,
    output cpu_dp_pkg::s_r_wb_t  s_r_wb,
    output cpu_isa_pkg::alu_op_t alu_op,
    output logic                 arg_one,
    output logic                 acc_db,
    output logic                 keep_c,
    output logic                 inc_pc,
    output logic                 jr_add,
    output logic                 mem_rd,
    output logic                 mem_wr
);
    import cpu_isa_pkg::*;
    import cpu_dp_pkg::*;

    function automatic reg8_t r8_idx(input logic [2:0] field);
        reg8_t idx;
        case (field)
            3'd0:    idx = B;
            3'd1:    idx = C;
            3'd2:    idx = D;
            3'd3:    idx = E;
            3'd4:    idx = H;
            3'd5:    idx = L;
            3'd7:    idx = A;
            default: idx = NONE;             // (HL) slot
        endcase
        return idx;
    endfunction

    reg8_t   r8_dst;
    reg8_t   r8_src;
    reg8_t   alu_dst;
    alu_op_t f_alu_op;
    logic    hl_op;
    byte_t   op;
    logic    imm;

    assign r8_dst   = r8_idx(ir[5:3]);
    assign r8_src   = r8_idx(ir[2:0]);
    assign f_alu_op = alu_op_t'(ir[5:3]);
    assign alu_dst  = (f_alu_op == ALU_CP) ? NONE : A;   // CP only updates flags
    assign cond     = cond_t'(ir[4:3]);

    // (HL) operand forms share patterns with kept opcodes and run as NOP
    assign hl_op = (ir[7:6] == 2'b00 && ir[5:3] == 3'b110 &&
                    (ir[2:1] == 2'b10 || ir[2:0] == 3'b110)) ||
                   (ir[7:6] == 2'b01 && (ir[5:3] == 3'b110 || ir[2:0] == 3'b110)) ||
                   (ir[7:6] == 2'b10 && ir[2:0] == 3'b110);
    assign op = hl_op ? byte_t'(NOP) : ir;

    always_comb begin
        done      = 1'b0;
        imm       = 1'b0;
        is_cond   = 1'b0;
        next_step = '0;
        s_ab      = AB_PC;
        s_db      = NONE;
        t_db      = NONE;
        s_r_wb    = R_WB_DB;
        alu_op    = f_alu_op;
        arg_one   = 1'b0;
        acc_db    = 1'b0;
        keep_c    = 1'b0;
        jr_add    = 1'b0;
        mem_wr    = 1'b0;

        casez ({op, step})
            {LD_R_N, 3'd0}:   imm = 1'b1;
            {LD_R_N, 3'd1}: begin
                done = 1'b1;
                s_db = Z;
                t_db = r8_dst;
            end
            {LD_R_R, 3'd0}: begin
                done = 1'b1;
                s_db = r8_src;
                t_db = r8_dst;
            end
            {ALU_A_R, 3'd0}: begin
                done   = 1'b1;
                s_db   = r8_src;
                t_db   = alu_dst;
                s_r_wb = R_WB_ALU;
            end
            {ALU_A_N, 3'd0}:  imm = 1'b1;
            {ALU_A_N, 3'd1}: begin
                done   = 1'b1;
                s_db   = Z;
                t_db   = alu_dst;
                s_r_wb = R_WB_ALU;
            end
            {INCDEC_R, 3'd0}: begin
                done    = 1'b1;
                s_db    = r8_dst;
                t_db    = r8_dst;
                s_r_wb  = R_WB_ALU;
                acc_db  = 1'b1;              // Operand comes from the bus, not A
                arg_one = 1'b1;
                keep_c  = 1'b1;
                alu_op  = ir[0] ? ALU_SUB : ALU_ADD;
            end
            {JR_E, 3'd0}:     imm = 1'b1;
            {JR_E, 3'd1}:     jr_add = 1'b1;
            {JR_E, 3'd2}:     done = 1'b1;
            {JR_CC_E, 3'd0}: begin
                imm       = 1'b1;
                is_cond   = 1'b1;
                next_step = `CPU_STEP_W'd3;  // Not taken
            end
            {JR_CC_E, 3'd1}:  jr_add = 1'b1;
            {JR_CC_E, 3'd2},
            {JR_CC_E, 3'd3}:  done = 1'b1;
            {LDH_N_A, 3'd0}:  imm = 1'b1;
            {LDH_N_A, 3'd1}: begin
                s_ab   = AB_HIGH_Z;
                s_db   = A;
                mem_wr = 1'b1;
            end
            {LDH_N_A, 3'd2}:  done = 1'b1;
            default:          done = 1'b1;   // NOP and unsupported opcodes
        endcase

        // Immediate and opcode fetches both read [PC] and step PC
        mem_rd = done || imm;
        inc_pc = done || imm;
        if (imm) begin
            s_db = MEM;
            t_db = Z;
        end
    end

endmodule

// ==== design/cpu_alu.sv ====
`include "cpu_defs.svh"

module cpu_alu (
    input  cpu_isa_pkg::alu_op_t op,
    input  cpu_dp_pkg::byte_t    acc,
    input  cpu_dp_pkg::byte_t    arg,
    input  logic                 carry_in,
    output cpu_dp_pkg::byte_t    result,
    output cpu_dp_pkg::flags_t   flags_out
);
    import cpu_isa_pkg::*;

    logic                 sub;
    logic                 cin;
    logic [4:0]           nib;               // Bit 4 is carry or borrow out of bit 3
    logic [`CPU_DATA_W:0] sum;

    assign sub = (op == ALU_SUB) || (op == ALU_SBC) || (op == ALU_CP);
    assign cin = ((op == ALU_ADC) || (op == ALU_SBC)) && carry_in;

    always_comb begin
        if (sub) begin
            nib = {1'b0, acc[3:0]} - {1'b0, arg[3:0]} - {4'b0, cin};
            sum = {1'b0, acc} - {1'b0, arg} - {{`CPU_DATA_W{1'b0}}, cin};
        end else begin
            nib = {1'b0, acc[3:0]} + {1'b0, arg[3:0]} + {4'b0, cin};
            sum = {1'b0, acc} + {1'b0, arg} + {{`CPU_DATA_W{1'b0}}, cin};
        end

        result      = sum[`CPU_DATA_W-1:0];
        flags_out.n = sub;
        flags_out.h = nib[4];
        flags_out.c = sum[`CPU_DATA_W];

        case (op)
            ALU_AND: begin
                result      = acc & arg;
                flags_out.h = 1'b1;
                flags_out.c = 1'b0;
            end
            ALU_XOR: begin
                result      = acc ^ arg;
                flags_out.h = 1'b0;
                flags_out.c = 1'b0;
            end
            ALU_OR: begin
                result      = acc | arg;
                flags_out.h = 1'b0;
                flags_out.c = 1'b0;
            end
            default: ;
        endcase

        flags_out.z = (result == '0);
    end

endmodule

// ==== design/cpu_regs.sv ====
`include "cpu_defs.svh"

module cpu_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 step_done,
    input  cpu_dp_pkg::ab_sel_t  s_ab,
    input  cpu_isa_pkg::reg8_t   s_db,
    input  cpu_isa_pkg::reg8_t   t_db,
    input  cpu_dp_pkg::s_r_wb_t  s_r_wb,
    input  cpu_isa_pkg::alu_op_t alu_op,
    input  logic                 arg_one,
    input  logic                 acc_db,
    input  logic                 keep_c,
    input  logic                 inc_pc,
    input  logic                 jr_add,
    input  cpu_dp_pkg::byte_t    rd_data,
    output cpu_dp_pkg::flags_t   flags,
    output cpu_dp_pkg::addr_t    mem_addr,
    output cpu_dp_pkg::byte_t    mem_wdata
);
    import cpu_isa_pkg::*;
    import cpu_dp_pkg::*;

    byte_t  b, c, d, e, h, l, a, z;
    addr_t  pc;
    s_db_t  db_src;
    byte_t  db;                              // Internal data bus
    byte_t  alu_acc;
    byte_t  alu_arg;
    byte_t  alu_res;
    byte_t  wb;
    flags_t alu_flags;
    addr_t  z_sext;

    assign db_src = s_db_t'(s_db);

    always_comb begin
        case (db_src)
            DB_Z:    db = z;
            DB_B:    db = b;
            DB_C:    db = c;
            DB_D:    db = d;
            DB_E:    db = e;
            DB_H:    db = h;
            DB_L:    db = l;
            DB_A:    db = a;
            DB_MEM:  db = rd_data;
            default: db = '0;
        endcase
    end

    assign alu_acc = acc_db ? db : a;
    assign alu_arg = arg_one ? byte_t'(1) : db;  // INC and DEC step by one

    cpu_alu u_alu (
        .op        (alu_op),
        .acc       (alu_acc),
        .arg       (alu_arg),
        .carry_in  (flags.c),
        .result    (alu_res),
        .flags_out (alu_flags)
    );

    assign wb        = (s_r_wb == R_WB_ALU) ? alu_res : db;
    assign z_sext    = {{(`CPU_ADDR_W - `CPU_DATA_W){z[`CPU_DATA_W-1]}}, z};
    assign mem_addr  = (s_ab == AB_HIGH_Z) ? {`CPU_HIGH_PAGE, z} : pc;
    assign mem_wdata = db;

    always_ff @(posedge clk) begin
        if (step_done) begin
            case (t_db)
                Z:       z <= wb;
                B:       b <= wb;
                C:       c <= wb;
                D:       d <= wb;
                E:       e <= wb;
                H:       h <= wb;
                L:       l <= wb;
                A:       a <= wb;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc    <= `CPU_RESET_PC;
            flags <= '0;
        end else if (step_done) begin
            if (jr_add) begin
                pc <= pc + z_sext;           // PC already points past the offset
            end else if (inc_pc) begin
                pc <= pc + addr_t'(1);
            end
            if (s_r_wb == R_WB_ALU) begin
                flags <= {alu_flags.z, alu_flags.n, alu_flags.h,
                          keep_c ? flags.c : alu_flags.c};
            end
        end
    end

endmodule

// ==== design/cpu_bus_ctrl.sv ====
`include "cpu_defs.svh"

module cpu_bus_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_rd,
    input  logic                   mem_wr,
    input  logic                   mem_ack,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,
    output logic                   mem_req,
    output logic                   mem_we,
    output logic                   step_done,
    output cpu_dp_pkg::byte_t      rd_data
);
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE,
        FINISH
    } state_t;

    state_t state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= IDLE;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (!(mem_rd || mem_wr)) begin
                        state <= FINISH;     // Internal step takes one cycle
                    end else if (!mem_ack) begin
                        state   <= REQ;
                        mem_req <= 1'b1;
                        mem_we  <= mem_wr;
                    end
                end
                REQ: begin
                    if (mem_ack) begin
                        state   <= RELEASE;
                        mem_req <= 1'b0;
                        mem_we  <= 1'b0;
                    end
                end
                RELEASE: begin
                    if (!mem_ack) begin
                        state <= FINISH;
                    end
                end
                default: state <= IDLE;      // FINISH lasts one cycle
            endcase
        end
    end

    // Read data is captured while ack is high
    always_ff @(posedge clk) begin
        if (state == REQ && mem_ack) begin
            rd_data <= mem_rdata;
        end
    end

    assign step_done = (state == FINISH);

endmodule

// ==== design/cpu_top.sv ====
`include "cpu_defs.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   mem_req,
    output logic                   mem_we,
    output logic [`CPU_ADDR_W-1:0] mem_addr,
    output logic [`CPU_DATA_W-1:0] mem_wdata,
    input  logic                   mem_ack,
    input  logic [`CPU_DATA_W-1:0] mem_rdata
);
    import cpu_isa_pkg::*;
    import cpu_dp_pkg::*;

    byte_t   ir;
    step_t   step;
    step_t   next_step;
    logic    done;
    logic    is_cond;
    cond_t   cond;
    flags_t  flags;
    ab_sel_t s_ab;
    reg8_t   s_db;
    reg8_t   t_db;
    s_r_wb_t s_r_wb;
    alu_op_t alu_op;
    logic    arg_one;
    logic    acc_db;
    logic    keep_c;
    logic    inc_pc;
    logic    jr_add;
    logic    mem_rd;
    logic    mem_wr;
    logic    step_done;
    byte_t   rd_data;

    cpu_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .step_done (step_done),
        .done      (done),
        .is_cond   (is_cond),
        .cond      (cond),
        .next_step (next_step),
        .flags     (flags),
        .rd_data   (rd_data),
        .ir        (ir),
        .step      (step)
    );

    cpu_decoder u_dec (
        .ir        (ir),
        .step      (step),
        .done      (done),
        .is_cond   (is_cond),
        .cond      (cond),
        .next_step (next_step),
        .s_ab      (s_ab),
        .s_db      (s_db),
        .t_db      (t_db),
        .s_r_wb    (s_r_wb),
        .alu_op    (alu_op),
        .arg_one   (arg_one),
        .acc_db    (acc_db),
        .keep_c    (keep_c),
        .inc_pc    (inc_pc),
        .jr_add    (jr_add),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr)
    );

    cpu_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .step_done (step_done),
        .s_ab      (s_ab),
        .s_db      (s_db),
        .t_db      (t_db),
        .s_r_wb    (s_r_wb),
        .alu_op    (alu_op),
        .arg_one   (arg_one),
        .acc_db    (acc_db),
        .keep_c    (keep_c),
        .inc_pc    (inc_pc),
        .jr_add    (jr_add),
        .rd_data   (rd_data),
        .flags     (flags),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    cpu_bus_ctrl u_bus (
        .clk       (clk),
        .rst       (rst),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .step_done (step_done),
        .rd_data   (rd_data)
    );

endmodule

// ==== tb/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;               // 8 ns period
    end

    initial begin
        rst = 1'b1;
        #1 rst = 1'b0;                       // Reset edge after time zero
        repeat (10) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

// ==== tb/cpu_tb.sv ====
module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RB = 0;
    localparam int RC = 1;
    localparam int RD = 2;
    localparam int RE = 3;
    localparam int RH = 4;
    localparam int RL = 5;
    localparam int RA = 7;

    logic        clk;
    logic        rst;
    logic        mem_req;
    logic        mem_we;
    logic [15:0] mem_addr;
    logic [7:0]  mem_wdata;
    logic        mem_ack = 1'b0;
    logic [7:0]  mem_rdata = 8'h00;

    logic [7:0]  mem [0:65535];
    logic [15:0] exp_addr_q[$];
    logic [7:0]  exp_data_q[$];
    logic [15:0] exp_addr;
    logic [7:0]  exp_data;
    logic        exp_valid;
    logic        first_seen;
    int          store_idx;
    int          n_exp;
    int          wait_cnt;
    int          pc_e;
    int          next_port;
    integer      seed = 75115;
    logic [7:0]  rf [0:7];                   // Architectural model of B..A
    logic        fz;
    logic        fc;
    bit          built = 1'b0;

    tb_clk_gen clk_gen0 (.clk(clk), .rst(rst));

    cpu_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // Reference ALU returning {z, n, h, c, result}
    function automatic logic [11:0] alu_model(input int op, input logic [7:0] x,
                                              input logic [7:0] y, input logic cf);
        int         ai;
        int         bi;
        int         ci;
        int         t;
        logic [7:0] r;
        logic       h;
        logic       c;
        logic       n;
        ai = x;
        bi = y;
        ci = (op == 1 || op == 3) ? int'(cf) : 0;
        n  = (op == 2 || op == 3 || op == 7);
        case (op)
            0, 1: begin
                t = ai + bi + ci;
                r = t[7:0];
                h = ((ai & 15) + (bi & 15) + ci) > 15;
                c = t > 255;
            end
            4: begin
                r = x & y;
                h = 1'b1;
                c = 1'b0;
            end
            5: begin
                r = x ^ y;
                h = 1'b0;
                c = 1'b0;
            end
            6: begin
                r = x | y;
                h = 1'b0;
                c = 1'b0;
            end
            default: begin                   // SUB, SBC and CP
                t = ai - bi - ci;
                r = t[7:0];
                h = (ai & 15) < ((bi & 15) + ci);
                c = ai < (bi + ci);
            end
        endcase
        return {r == 8'h00, n, h, c, r};
    endfunction

    function automatic logic cond_ok(input int cc);
        case (cc)
            0:       return !fz;
            1:       return fz;
            2:       return !fc;
            default: return fc;
        endcase
    endfunction

    task automatic put(input logic [7:0] v);
        mem[pc_e] = v;
        pc_e++;
    endtask

    task automatic apply_alu(input int op, input logic [7:0] arg);
        logic [11:0] res;
        res = alu_model(op, rf[RA], arg, fc);
        fz = res[11];
        fc = res[8];
        if (op != 7) begin
            rf[RA] = res[7:0];               // CP keeps A
        end
    endtask

    task automatic load_imm(input int r, input logic [7:0] n);
        put({2'b00, 3'(r), 3'b110});
        put(n);
        rf[r] = n;
    endtask

    task automatic copy_reg(input int d, input int s);
        put({2'b01, 3'(d), 3'(s)});
        rf[d] = rf[s];
    endtask

    task automatic alu_imm(input int op, input logic [7:0] n);
        put({2'b11, 3'(op), 3'b110});
        put(n);
        apply_alu(op, n);
    endtask

    task automatic alu_reg(input int op, input int r);
        put({2'b10, 3'(op), 3'(r)});
        apply_alu(op, rf[r]);
    endtask

    task automatic step_reg(input int r, input logic is_dec);
        logic [11:0] res;
        put({2'b00, 3'(r), 2'b10, is_dec});
        res = alu_model(is_dec ? 2 : 0, rf[r], 8'h01, 1'b0);
        fz = res[11];                        // Carry is left alone
        rf[r] = res[7:0];
    endtask

    task automatic store_a();
        put(8'hE0);
        put(8'(next_port));
        exp_addr_q.push_back({8'hFF, 8'(next_port)});
        exp_data_q.push_back(rf[RA]);
        next_port++;
    endtask

    // LD A,m then LDH (n),A on a path that may be skipped
    task automatic marker_store(input logic [7:0] m, input logic executed);
        put({2'b00, 3'd7, 3'b110});
        put(m);
        put(8'hE0);
        put(8'(next_port));
        if (executed) begin
            rf[RA] = m;
            exp_addr_q.push_back({8'hFF, 8'(next_port)});
            exp_data_q.push_back(m);
        end
        next_port++;
    endtask

    task automatic jr_cond_test(input int cc, input logic want, input int idx);
        logic [7:0] operand;
        logic       taken;
        case (cc)
            0:       operand = want ? 8'h30 : 8'h40;
            1:       operand = want ? 8'h40 : 8'h30;
            2:       operand = want ? 8'h30 : 8'h50;
            default: operand = want ? 8'h50 : 8'h30;
        endcase
        load_imm(RA, 8'h40);
        alu_imm(7, operand);                 // CP sets z and c
        taken = cond_ok(cc);
        put({3'b001, 2'(cc), 3'b000});
        put(8'h04);
        marker_store(8'hA0 + 8'(idx), !taken);
        marker_store(8'hB0 + 8'(idx), 1'b1);
    endtask

    task automatic build_program();
        load_imm(RB, 8'h3C);
        copy_reg(RD, RB);
        copy_reg(RA, RD);
        store_a();
        load_imm(RC, 8'h5A);
        copy_reg(RE, RC);
        copy_reg(RH, RE);
        copy_reg(RL, RH);
        copy_reg(RA, RL);
        store_a();
        // ALU operations with carry and borrow cases
        load_imm(RA, 8'hF8);
        alu_imm(0, 8'h10);
        store_a();
        alu_imm(1, 8'h01);
        store_a();
        load_imm(RA, 8'h80);
        load_imm(RB, 8'h80);
        alu_reg(0, RB);
        store_a();
        alu_reg(1, RB);
        store_a();
        load_imm(RA, 8'h10);
        alu_imm(2, 8'h20);
        store_a();
        alu_imm(3, 8'h01);
        store_a();
        load_imm(RC, 8'h05);
        load_imm(RA, 8'h03);
        alu_reg(2, RC);
        store_a();
        alu_reg(3, RC);
        store_a();
        load_imm(RA, 8'hF0);
        alu_imm(4, 8'h3C);
        store_a();
        load_imm(RE, 8'hFF);
        alu_reg(5, RE);
        store_a();
        alu_imm(6, 8'h30);
        store_a();
        load_imm(RD, 8'h0F);
        alu_reg(4, RD);
        store_a();
        load_imm(RA, 8'h42);
        alu_imm(7, 8'h50);
        store_a();
        alu_imm(1, 8'h00);                   // Uses borrow left by CP
        store_a();
        load_imm(RL, 8'h43);
        alu_reg(7, RL);
        alu_imm(3, 8'h00);
        store_a();
        // INC and DEC keep the carry
        load_imm(RA, 8'hFF);
        alu_imm(0, 8'h01);
        load_imm(RB, 8'h10);
        step_reg(RB, 1'b0);
        load_imm(RA, 8'h20);
        alu_reg(1, RB);
        store_a();
        load_imm(RA, 8'hF0);
        alu_imm(0, 8'h20);
        load_imm(RH, 8'h01);
        step_reg(RH, 1'b1);
        load_imm(RA, 8'h05);
        alu_reg(1, RH);
        store_a();
        load_imm(RA, 8'hFF);
        step_reg(RA, 1'b0);
        store_a();
        // Unconditional jump forward over a store
        put(8'h18);
        put(8'h04);
        marker_store(8'hBD, 1'b0);
        marker_store(8'hC1, 1'b1);
        // Forward jump, store, then backward jump into the store
        put(8'h18);
        put(8'h06);
        marker_store(8'hC2, 1'b1);
        put(8'h18);
        put(8'h02);
        put(8'h18);
        put(8'hF8);
        for (int cc = 0; cc < 4; cc++) begin
            jr_cond_test(cc, 1'b1, 2 * cc);
            jr_cond_test(cc, 1'b0, 2 * cc + 1);
        end
        marker_store(8'hEE, 1'b1);
        put(8'h18);
        put(8'hFE);                          // Spin in place
    endtask

    // Memory model with a random ack delay
    always @(posedge clk) begin
        if (!rst) begin
            mem_ack    <= 1'b0;
            mem_rdata  <= 8'h00;
            wait_cnt   <= $random(seed) & 3;
            store_idx  <= 0;
            first_seen <= 1'b0;
            exp_addr   <= exp_addr_q[0];
            exp_data   <= exp_data_q[0];
            exp_valid  <= 1'b1;
        end else begin
            if (mem_req) begin
                first_seen <= 1'b1;
            end
            if (mem_req && !mem_ack) begin
                if (wait_cnt == 0) begin
                    mem_ack   <= 1'b1;
                    mem_rdata <= mem[mem_addr];
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (mem_req && mem_ack && mem_we) begin
                mem[mem_addr] <= mem_wdata;
                store_idx     <= store_idx + 1;
                if (store_idx + 1 < n_exp) begin
                    exp_addr <= exp_addr_q[store_idx + 1];
                    exp_data <= exp_data_q[store_idx + 1];
                end else begin
                    exp_valid <= 1'b0;
                end
            end else if (!mem_req && mem_ack) begin
                mem_ack  <= 1'b0;
                wait_cnt <= $random(seed) & 3;
            end
        end
    end

    assert property (@(posedge clk) !rst |-> !mem_req)
        else fail_now("mem_req went high during reset");

    assert property (@(posedge clk) disable iff (!rst)
                     (mem_req && !first_seen) |-> (!mem_we && mem_addr == 16'h0000))
        else fail_now("First request after reset is not a read of address 0000");

    assert property (@(posedge clk) disable iff (!rst) $fell(mem_req) |-> $past(mem_ack))
        else fail_now("mem_req dropped before mem_ack was seen high");

    assert property (@(posedge clk) disable iff (!rst) $rose(mem_req) |-> !$past(mem_ack))
        else fail_now("mem_req rose while mem_ack was still high");

    assert property (@(posedge clk) disable iff (!rst)
                     (mem_req && $past(mem_req)) |->
                     ($stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata)))
        else fail_now("Address, we or wdata changed while mem_req was high");

    assert property (@(posedge clk) disable iff (!rst)
                     (mem_req && !mem_we) |-> (int'(mem_addr) < pc_e))
        else fail_now("Instruction fetch outside the program area");

    assert property (@(posedge clk) disable iff (!rst)
                     (mem_req && mem_ack && mem_we) |-> exp_valid)
        else fail_now("Store seen after the last expected store");

    assert property (@(posedge clk) disable iff (!rst)
                     (mem_req && mem_ack && mem_we) |-> (mem_addr == exp_addr))
        else fail_now($sformatf("ERROR: %0d ns mem_addr expected %h got %h",
                                $time, $sampled(exp_addr), $sampled(mem_addr)));

    assert property (@(posedge clk) disable iff (!rst)
                     (mem_req && mem_ack && mem_we) |-> (mem_wdata == exp_data))
        else fail_now($sformatf("ERROR: %0d ns mem_wdata expected %h got %h",
                                $time, $sampled(exp_data), $sampled(mem_wdata)));

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i ^ (i >> 8));       // Background pattern
        end
        pc_e      = 0;
        next_port = 0;
        fz        = 1'b0;
        fc        = 1'b0;
        build_program();
        n_exp = exp_addr_q.size();
        built = 1'b1;
        wait (rst);
        wait (store_idx == n_exp);
        repeat (20) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

    // Each byte costs at most a few steps of up to about 10 cycles each
    initial begin
        longint limit_ns;
        wait (built);
        limit_ns = longint'((3 * pc_e + 20) * 10 * 8 + 2000);
        #(limit_ns);
        fail_now($sformatf("Timeout after %0d ns with %0d of %0d stores seen",
                           limit_ns, store_idx, n_exp));
    end

endmodule

// ==== verilog.f ====
+incdir+include
design/cpu_isa_pkg.sv
design/cpu_dp_pkg.sv
design/cpu_sequencer.sv
design/cpu_decoder.sv
design/cpu_alu.sv
design/cpu_regs.sv
design/cpu_bus_ctrl.sv
design/cpu_top.sv
tb/tb_clk_gen.sv
tb/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - include_dirs:
      - include
    files:
      - design/cpu_isa_pkg.sv
      - design/cpu_dp_pkg.sv
      - design/cpu_sequencer.sv
      - design/cpu_decoder.sv
      - design/cpu_alu.sv
      - design/cpu_regs.sv
      - design/cpu_bus_ctrl.sv
      - design/cpu_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/cpu_tb.sv
